// File: Bender.yml
package:
  name: credit_link

sources:
  - include_dirs:
      - include
    files:
      - src/credit_link_pkg.sv
      - src/credit_gray_ptr.sv
      - src/async_credit_counter.sv
      - src/packet_sender.sv
      - src/cdc_word_buffer.sv
      - src/packet_consumer.sv
      - src/credit_link_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - bench/credit_link_assert.sv
      - bench/credit_link_tb.sv

// File: all.f
+incdir+include
src/credit_link_pkg.sv
src/credit_gray_ptr.sv
src/async_credit_counter.sv
src/packet_sender.sv
src/cdc_word_buffer.sv
src/packet_consumer.sv
src/credit_link_top.sv
bench/credit_link_assert.sv
bench/credit_link_tb.sv

// File: bench/credit_link_assert.sv
// ****************************************
// credit link assertions
// protocol checks bound onto the top level
// ****************************************
`default_nettype none
`include "credit_link_macros.svh"

module credit_link_assert (
   input logic                        r_clk_i,
   input logic                        r_reset_i,
   input logic                        w_clk_i,
   input logic                        w_reset_i,
   input logic                        r_wr_i,
   input logic [$clog2(`BUF_DEPTH):0] r_wr_ptr_i,
   input logic [$clog2(`BUF_DEPTH):0] w_rd_ptr_i,
   input logic                        r_busy_i,
   input logic                        w_pkt_valid_i
);

   // words written but not yet read, as seen at the r edge
   logic [$clog2(`BUF_DEPTH):0] fill_words;

   // failed assertions so far
   int fail_cnt = 0;

   assign fill_words = r_wr_ptr_i - w_rd_ptr_i;

   // a credit in hand always leaves a free slot in the buffer
   write_finds_room: assert property (
      @(posedge r_clk_i) disable iff (r_reset_i) r_wr_i |-> fill_words < `BUF_DEPTH
   ) else begin
      $error("buffer write with every slot still occupied");
      fail_cnt = fail_cnt + 1;
   end

   // the packet report is a single-cycle pulse
   valid_single_cycle: assert property (
      @(posedge w_clk_i) disable iff (w_reset_i) w_pkt_valid_i |=> !w_pkt_valid_i
   ) else begin
      $error("packet valid held for more than one cycle");
      fail_cnt = fail_cnt + 1;
   end

   // first cycle out of reset sees an idle sender
   idle_after_reset: assert property (
      @(posedge r_clk_i) $fell(r_reset_i) |-> !r_busy_i
   ) else begin
      $error("sender busy in the cycle after reset");
      fail_cnt = fail_cnt + 1;
   end

endmodule

bind credit_link_top credit_link_assert u_assert (
   .r_clk_i      (r_clk_i),
   .r_reset_i    (r_reset_i),
   .w_clk_i      (w_clk_i),
   .w_reset_i    (w_reset_i),
   .r_wr_i       (r_wr),
   .r_wr_ptr_i   (u_buffer.r_wr_ptr_bin),
   .w_rd_ptr_i   (u_buffer.w_rd_ptr_bin_r),
   .r_busy_i     (r_busy_o),
   .w_pkt_valid_i(w_pkt_valid_o)
);

`default_nettype wire

// File: bench/credit_link_tb.sv
// ****************************************
// credit link testbench
// replays packet trace, paces the drain, checks every reported packet
// ****************************************
`default_nettype none
`include "credit_link_macros.svh"

module credit_link_tb;

   import credit_link_pkg::*;

   localparam string       trace_path_lp   = "bench/credit_link_trace.txt";
   localparam int          reset_cycles_lp = 16;
   localparam int          drive_delay_lp  = 1;
   // token return takes a w edge plus the r synchronizer and far fewer cycles than this
   localparam int          settle_cycles_lp = 10;
   localparam logic [31:0] lfsr_seed_lp    = 32'h837333ad;

   logic        r_clk_i;
   logic        r_reset_i;
   logic        r_start_i;
   dest_t       r_dest_i;
   len_t        r_len_i;
   logic [14:0] r_seed_i;
   logic        r_busy_o;
   logic        w_clk_i;
   logic        w_reset_i;
   logic        w_drain_en_i;
   logic        w_pkt_valid_o;
   dest_t       w_pkt_dest_o;
   len_t        w_pkt_len_o;
   sum_t        w_pkt_sum_o;
   logic        r_credits_avail_o;

   // trace contents with one entry per packet
   dest_t       tr_dest [$];
   len_t        tr_len  [$];
   logic [14:0] tr_seed [$];
   sum_t        tr_sum  [$];
   int          tr_hold [$];

   // trace indices of packets started but not yet reported
   int exp_idx [$];

   int issued        = 0;
   int reported      = 0;
   int total_words   = 0;
   int timeout_limit = 0;
   bit limit_ready   = 1'b0;
   bit w_ready       = 1'b0;
   bit run_done      = 1'b0;
   bit drain_off     = 1'b0;

   credit_link_top dut (
      .r_clk_i          (r_clk_i),
      .r_reset_i        (r_reset_i),
      .r_start_i        (r_start_i),
      .r_dest_i         (r_dest_i),
      .r_len_i          (r_len_i),
      .r_seed_i         (r_seed_i),
      .r_busy_o         (r_busy_o),
      .w_clk_i          (w_clk_i),
      .w_reset_i        (w_reset_i),
      .w_drain_en_i     (w_drain_en_i),
      .w_pkt_valid_o    (w_pkt_valid_o),
      .w_pkt_dest_o     (w_pkt_dest_o),
      .w_pkt_len_o      (w_pkt_len_o),
      .w_pkt_sum_o      (w_pkt_sum_o),
      .r_credits_avail_o(r_credits_avail_o)
   );

   // the two clocks are unrelated with periods of 10 and 14 time units
   always #5 r_clk_i = ~r_clk_i;
   always #7 w_clk_i = ~w_clk_i;

   // ****************************************
   // helpers
   // ****************************************

   task automatic report_failure();
      $display("Done: errors found");
      $fatal(1, "run stopped at the first error");
   endtask

   task automatic check_dest(input string name, input dest_t got, input dest_t exp);
      if (got !== exp) begin
         $display("[FAIL] time %0t %s: got 'h%0h expected 'h%0h", $time, name, got, exp);
         report_failure();
      end
   endtask

   task automatic check_len(input string name, input len_t got, input len_t exp);
      if (got !== exp) begin
         $display("[FAIL] time %0t %s: got %0d expected %0d", $time, name, got, exp);
         report_failure();
      end
   endtask

   task automatic check_sum(input string name, input sum_t got, input sum_t exp);
      if (got !== exp) begin
         $display("[FAIL] time %0t %s: got 'h%04h expected 'h%04h", $time, name, got, exp);
         report_failure();
      end
   endtask

   task automatic check_level(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("[FAIL] time %0t %s: got %b expected %b", $time, name, got, exp);
         report_failure();
      end
   endtask

   task automatic check_count(input string name, input int got, input int exp);
      if (got != exp) begin
         $display("[FAIL] time %0t %s: got %0d expected %0d", $time, name, got, exp);
         report_failure();
      end
   endtask

   // payload word k is seed plus k in 15 bits and the total wraps at 16 bits
   function automatic sum_t payload_sum(input logic [14:0] seed, input len_t len);
      sum_t        total;
      logic [14:0] word;
      total = '0;
      word  = seed;
      for (int k = 0; k < int'(len); k++) begin
         total = total + sum_t'(word);
         word  = word + 15'd1;
      end
      return total;
   endfunction

   // the new bit from taps 32 22 2 and 1 is the one handed out
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   // every drive and sample happens this long after the r edge
   task automatic r_cycle();
      @(posedge r_clk_i);
      #(drive_delay_lp);
   endtask

   task automatic load_trace();
      int          fd;
      int          n;
      string       line;
      dest_t       d;
      len_t        l;
      logic [14:0] s;
      sum_t        e;
      int          h;
      fd = $fopen(trace_path_lp, "r");
      if (fd == 0) begin
         $display("could not open the trace file %s", trace_path_lp);
         report_failure();
      end else begin
         while ($fgets(line, fd) != 0) begin
            n = 0;
            // lines starting with # describe the columns
            if (line.len() > 0 && line.getc(0) != "#") begin
               n = $sscanf(line, "%h %h %h %h %d", d, l, s, e, h);
            end
            if (n == 5) begin
               if (l == 0 || payload_sum(s, l) != e) begin
                  $display("trace line for dest 'h%0h has a zero length or a wrong sum", d);
                  report_failure();
               end else begin
                  tr_dest.push_back(d);
                  tr_len.push_back(l);
                  tr_seed.push_back(s);
                  tr_sum.push_back(e);
                  tr_hold.push_back(h);
               end
            end
         end
         $fclose(fd);
         if (tr_dest.size() == 0) begin
            $display("the trace file holds no packets");
            report_failure();
         end
      end
   endtask

   // start strobes for one cycle and busy must be up on the following cycle
   task automatic start_packet(input int i);
      while (r_busy_o) begin
         r_cycle();
      end
      r_start_i = 1'b1;
      r_dest_i  = tr_dest[i];
      r_len_i   = tr_len[i];
      r_seed_i  = tr_seed[i];
      exp_idx.push_back(i);
      issued++;
      total_words += int'(tr_len[i]) + 1;
      r_cycle();
      r_start_i = 1'b0;
      check_level("r_busy_o", r_busy_o, 1'b1);
   endtask

   // ****************************************
   // back-pressure packet
   // ****************************************

   // with the link idle and drain off, the sender may spend the whole buffer
   // less one credit when an odd word count left a token half-paid
   task automatic run_stall_packet(input int i);
      int writes;
      int exp_writes;
      while (reported != issued) begin
         r_cycle();
      end
      repeat (settle_cycles_lp) r_cycle();
      exp_writes = `BUF_DEPTH - (total_words % 2);
      drain_off  = 1'b1;
      start_packet(i);
      writes = 0;
      // a sending cycle with credits is a write at the next edge
      while (r_credits_avail_o && writes <= `BUF_DEPTH) begin
         if (r_busy_o) begin
            writes++;
         end
         r_cycle();
      end
      check_count("words written before stall", writes, exp_writes);
      for (int k = 0; k < tr_hold[i]; k++) begin
         check_level("r_credits_avail_o", r_credits_avail_o, 1'b0);
         check_level("r_busy_o", r_busy_o, 1'b1);
         r_cycle();
      end
      drain_off = 1'b0;
   endtask

   // ****************************************
   // processes
   // ****************************************

   initial begin : stimulus
      r_clk_i      = 1'b0;
      w_clk_i      = 1'b0;
      r_reset_i    = 1'b1;
      w_reset_i    = 1'b1;
      r_start_i    = 1'b0;
      r_dest_i     = '0;
      r_len_i      = '0;
      r_seed_i     = '0;
      w_drain_en_i = 1'b0;
      load_trace();
      timeout_limit = 200;
      foreach (tr_len[i]) begin
         timeout_limit += (int'(tr_len[i]) + 1) * 40;
      end
      limit_ready = 1'b1;
      repeat (reset_cycles_lp) @(posedge r_clk_i);
      #(drive_delay_lp);
      r_reset_i = 1'b0;
      wait (w_ready);
      r_cycle();
      // whole buffer is on credit and the sender is idle before any start
      check_level("r_credits_avail_o", r_credits_avail_o, 1'b1);
      check_level("r_busy_o", r_busy_o, 1'b0);
      for (int i = 0; i < tr_dest.size(); i++) begin
         if (tr_hold[i] != 0) begin
            run_stall_packet(i);
         end else begin
            start_packet(i);
         end
      end
      while (reported != issued) begin
         r_cycle();
      end
      repeat (settle_cycles_lp) r_cycle();
      check_level("r_credits_avail_o", r_credits_avail_o, 1'b1);
      run_done = 1'b1;
      if (dut.u_assert.fail_cnt == 0) begin
         $display("Done: no errors");
         $finish;
      end else begin
         $display("%0d bound protocol assertions failed", dut.u_assert.fail_cnt);
         report_failure();
      end
   end

   initial begin : w_reset_release
      repeat (reset_cycles_lp) @(posedge w_clk_i);
      #(drive_delay_lp);
      w_reset_i = 1'b0;
      w_ready   = 1'b1;
   end

   // one LFSR bit per w cycle decides whether the consumer may drain
   initial begin : drain_pacing
      logic [31:0] lfsr;
      lfsr = lfsr_seed_lp;
      forever begin
         @(posedge w_clk_i);
         #(drive_delay_lp);
         lfsr         = lfsr_step(lfsr);
         w_drain_en_i = lfsr[0] & ~drain_off;
      end
   end

   // packets must come back in trace order
   initial begin : result_monitor
      int idx;
      forever begin
         @(posedge w_clk_i);
         #(drive_delay_lp);
         if (w_pkt_valid_o) begin
            if (exp_idx.size() == 0) begin
               $display("a packet was reported at time %0t with none outstanding", $time);
               report_failure();
            end else begin
               idx = exp_idx.pop_front();
               check_dest("w_pkt_dest_o", w_pkt_dest_o, tr_dest[idx]);
               check_len("w_pkt_len_o", w_pkt_len_o, tr_len[idx]);
               check_sum("w_pkt_sum_o", w_pkt_sum_o, tr_sum[idx]);
               reported++;
            end
         end
      end
   end

   // watch the bound protocol checks
   initial begin : assertion_watch
      wait (dut.u_assert.fail_cnt != 0);
      $display("a bound protocol assertion failed at time %0t", $time);
      report_failure();
   end

   initial begin : watchdog
      int cycles;
      cycles = 0;
      wait (limit_ready);
      while (!run_done && cycles < timeout_limit) begin
         @(posedge r_clk_i);
         cycles++;
      end
      if (!run_done) begin
         $display("timed out after %0d cycles with %0d of %0d packets reported",
                  cycles, reported, tr_dest.size());
         report_failure();
      end
   end

endmodule

`default_nettype wire

// File: bench/credit_link_trace.txt
# columns: dest len seed expected_sum in hex, then drain_hold in r cycles (decimal)
# a nonzero hold starts the packet with drain off and keeps it off after the stall
05 04 0010 0046 0
7f 01 1234 1234 0
12 02 0100 0201 0
33 ff 0000 7e81 60
01 01 7fff 7fff 0
02 02 7fff 7fff 0
40 01 0001 0001 0
41 03 7ffe fffd 0
00 10 0100 1078 0
6a c8 7f00 85bc 0
55 15 7ff8 002a 0
0c ff 0400 7a81 40
03 02 0005 000b 0
04 01 0007 0007 0
7e 07 0020 00f5 0

// File: include/credit_link_macros.svh
// ****************************************
// credit link sizes
// word width, buffer depth, token decimation and synchronizer depth
// ****************************************
`ifndef CREDIT_LINK_MACROS_SVH
`define CREDIT_LINK_MACROS_SVH

// width of one link word, header or data
`define LINK_W 16

// number of words the crossing buffer can hold
`define BUF_DEPTH 16

// log2 of credits per returned token, so one token is worth two credits
`define LG_DECIMATION 1

// tokens that cover the whole buffer
`define MAX_TOKENS (`BUF_DEPTH >> `LG_DECIMATION)

// flops in every gray pointer synchronizer
`define SYNC_STAGES 2

`endif

// File: src/async_credit_counter.sv
// ****************************************
// async credit counter
// spends credits in the r domain against tokens returned from the w domain
// ****************************************
`default_nettype none
`include "credit_link_macros.svh"

module async_credit_counter (
   input  logic r_clk_i,
   input  logic r_reset_i,
   input  logic r_dec_credit_i,
   input  logic w_clk_i,
   input  logic w_reset_i,
   input  logic w_inc_token_i,
   output logic r_credits_avail_o
);

   // token pointer needs to tell 0 .. MAX_TOKENS apart
   localparam int w_width_lp = $clog2(`MAX_TOKENS + 1);
   // spend count carries the extra low bits for credits inside one token
   localparam int r_width_lp = w_width_lp + `LG_DECIMATION;

   // the spend count starts MAX_TOKENS tokens behind the token pointer,
   // so the whole buffer is available right after reset
   localparam logic [w_width_lp-1:0] start_hi_lp = '0 - w_width_lp'(`MAX_TOKENS);

   logic [r_width_lp-1:0] r_count_r;
   logic [w_width_lp-1:0] r_count_hi;
   logic [w_width_lp-1:0] r_count_hi_gray;
   logic                  r_count_lo_nonzero;
   logic [w_width_lp-1:0] r_token_gray_sync;

   always_ff @(posedge r_clk_i) begin
      if (r_reset_i) begin
         r_count_r <= {start_hi_lp, {`LG_DECIMATION{1'b0}}};
      end else begin
         r_count_r <= r_count_r + r_width_lp'(r_dec_credit_i);
      end
   end

   // returned tokens cross as a gray pointer, the w side never sees spending
   credit_gray_ptr #(
      .ptr_width_p(w_width_lp)
   ) u_token_ptr (
      .launch_clk_i   (w_clk_i),
      .launch_reset_i (w_reset_i),
      .launch_inc_i   (w_inc_token_i),
      .capture_clk_i  (r_clk_i),
      .capture_reset_i(r_reset_i),
      .launch_gray_o  (),
      .capture_gray_o (r_token_gray_sync)
   );

   // ****************************************
   // availability compare
   // ****************************************

   // a partly spent token always leaves at least one credit
   assign r_count_lo_nonzero = |r_count_r[`LG_DECIMATION-1:0];
   assign r_count_hi         = r_count_r[`LG_DECIMATION +: w_width_lp];
   // compare in gray rather than decoding the synchronized pointer
   assign r_count_hi_gray    = r_count_hi ^ (r_count_hi >> 1);

   assign r_credits_avail_o = r_count_lo_nonzero | (r_count_hi_gray != r_token_gray_sync);

endmodule

`default_nettype wire

// File: src/cdc_word_buffer.sv
// ****************************************
// cdc word buffer
// dual-clock word store, write pointer crosses to the read side in gray
// ****************************************
`default_nettype none
`include "credit_link_macros.svh"

module cdc_word_buffer (
   input  logic                        r_clk_i,
   input  logic                        r_reset_i,
   input  logic                        r_wr_i,
   input  credit_link_pkg::link_word_u r_word_i,
   input  logic                        w_clk_i,
   input  logic                        w_reset_i,
   input  logic                        w_rd_i,
   output credit_link_pkg::link_word_u w_word_o,
   output logic                        w_nonempty_o
);

   import credit_link_pkg::*;

   localparam int addr_w_lp = $clog2(`BUF_DEPTH);
   // one extra bit tells a wrapped pointer from an equal one
   localparam int ptr_w_lp  = addr_w_lp + 1;

   logic [`LINK_W-1:0]  mem_r [`BUF_DEPTH];

   logic [ptr_w_lp-1:0]  r_wr_ptr_gray;
   logic [ptr_w_lp-1:0]  r_wr_ptr_bin;
   logic [addr_w_lp-1:0] r_wr_addr;
   logic [ptr_w_lp-1:0]  w_wr_ptr_gray_sync;

   logic [ptr_w_lp-1:0]  w_rd_ptr_bin_r;
   logic [ptr_w_lp-1:0]  w_rd_ptr_next;
   logic [ptr_w_lp-1:0]  w_rd_ptr_gray_r;

   function automatic logic [ptr_w_lp-1:0] gray_to_bin(input logic [ptr_w_lp-1:0] g);
      logic [ptr_w_lp-1:0] b;
      b[ptr_w_lp-1] = g[ptr_w_lp-1];
      for (int i = ptr_w_lp - 2; i >= 0; i--) begin
         b[i] = b[i+1] ^ g[i];
      end
      return b;
   endfunction

   // ****************************************
   // write side
   // ****************************************

   // write pointer lives in the gray counter, which also carries it across
   credit_gray_ptr #(
      .ptr_width_p(ptr_w_lp)
   ) u_wr_ptr (
      .launch_clk_i   (r_clk_i),
      .launch_reset_i (r_reset_i),
      .launch_inc_i   (r_wr_i),
      .capture_clk_i  (w_clk_i),
      .capture_reset_i(w_reset_i),
      .launch_gray_o  (r_wr_ptr_gray),
      .capture_gray_o (w_wr_ptr_gray_sync)
   );

   // the write address is decoded locally from the launch-side gray value
   assign r_wr_ptr_bin = gray_to_bin(r_wr_ptr_gray);
   assign r_wr_addr    = r_wr_ptr_bin[addr_w_lp-1:0];

   // no full check here, the sender only writes with a credit in hand
   always_ff @(posedge r_clk_i) begin
      if (r_wr_i) begin
         mem_r[r_wr_addr] <= r_word_i;
      end
   end

   // ****************************************
   // read side
   // ****************************************

   assign w_rd_ptr_next = w_rd_ptr_bin_r + ptr_w_lp'(1);

   always_ff @(posedge w_clk_i) begin
      if (w_reset_i) begin
         w_rd_ptr_bin_r  <= '0;
         w_rd_ptr_gray_r <= '0;
      end else if (w_rd_i) begin
         w_rd_ptr_bin_r  <= w_rd_ptr_next;
         w_rd_ptr_gray_r <= w_rd_ptr_next ^ (w_rd_ptr_next >> 1);
      end
   end

   // a word counts as present only after its pointer step has been synchronized
   assign w_nonempty_o = (w_rd_ptr_gray_r != w_wr_ptr_gray_sync);
   assign w_word_o     = mem_r[w_rd_ptr_bin_r[addr_w_lp-1:0]];

endmodule

`default_nettype wire

// File: src/credit_gray_ptr.sv
// ****************************************
// credit gray pointer
// gray-coded counter in one domain, synchronized into another
// ****************************************
`default_nettype none
`include "credit_link_macros.svh"

module credit_gray_ptr #(
   parameter int ptr_width_p = 4
) (
   input  logic                   launch_clk_i,
   input  logic                   launch_reset_i,
   input  logic                   launch_inc_i,
   input  logic                   capture_clk_i,
   input  logic                   capture_reset_i,
   output logic [ptr_width_p-1:0] launch_gray_o,
   output logic [ptr_width_p-1:0] capture_gray_o
);

   // binary count and its gray image, both in the launch domain
   logic [ptr_width_p-1:0] bin_r;
   logic [ptr_width_p-1:0] bin_next;
   logic [ptr_width_p-1:0] gray_r;

   // capture-domain synchronizer chain
   logic [ptr_width_p-1:0] sync_r [`SYNC_STAGES];

   assign bin_next = bin_r + ptr_width_p'(launch_inc_i);

   // the gray value comes straight from a flop so only one bit moves per step,
   // which is what makes sampling it in the other domain safe
   always_ff @(posedge launch_clk_i) begin
      if (launch_reset_i) begin
         bin_r  <= '0;
         gray_r <= '0;
      end else begin
         bin_r  <= bin_next;
         gray_r <= bin_next ^ (bin_next >> 1);
      end
   end

   // ****************************************
   // capture side
   // ****************************************

   // first stage may go metastable, later stages settle it
   always_ff @(posedge capture_clk_i) begin
      if (capture_reset_i) begin
         for (int i = 0; i < `SYNC_STAGES; i++) begin
            sync_r[i] <= '0;
         end
      end else begin
         sync_r[0] <= gray_r;
         for (int i = 1; i < `SYNC_STAGES; i++) begin
            sync_r[i] <= sync_r[i-1];
         end
      end
   end

   assign launch_gray_o  = gray_r;
   assign capture_gray_o = sync_r[`SYNC_STAGES-1];

endmodule

`default_nettype wire

// File: src/credit_link_pkg.sv
// ****************************************
// credit link package
// link word union and the packet field types
// ****************************************
`default_nettype none

package credit_link_pkg;

   // destination port of a packet
   typedef logic [6:0] dest_t;

   // payload word count of a packet, 1 to 255
   typedef logic [7:0] len_t;

   // payload sum, wraps modulo 2^16
   typedef logic [15:0] sum_t;

   // first word of a packet, kind bit is 1
   typedef struct packed {
      logic  kind;
      dest_t dest;
      len_t  len;
   } hdr_view_t;

   // payload word, kind bit is 0
   typedef struct packed {
      logic        kind;
      logic [14:0] payload;
   } data_view_t;

   // the same 16 bits, read either as a header or as payload
   typedef union packed {
      hdr_view_t  hdr;
      data_view_t data;
   } link_word_u;

endpackage

`default_nettype wire

// File: src/credit_link_top.sv
// ****************************************
// credit link top
// sender, crossing buffer, consumer and credit counter
// ****************************************
`default_nettype none

module credit_link_top (
   input  logic                   r_clk_i,
   input  logic                   r_reset_i,
   input  logic                   r_start_i,
   input  credit_link_pkg::dest_t r_dest_i,
   input  credit_link_pkg::len_t  r_len_i,
   input  logic [14:0]            r_seed_i,
   output logic                   r_busy_o,
   input  logic                   w_clk_i,
   input  logic                   w_reset_i,
   input  logic                   w_drain_en_i,
   output logic                   w_pkt_valid_o,
   output credit_link_pkg::dest_t w_pkt_dest_o,
   output credit_link_pkg::len_t  w_pkt_len_o,
   output credit_link_pkg::sum_t  w_pkt_sum_o,
   output logic                   r_credits_avail_o
);

   import credit_link_pkg::*;

   // r domain
   logic       r_wr;
   link_word_u r_word;
   // w domain
   logic       w_rd;
   logic       w_nonempty;
   logic       w_inc_token;
   link_word_u w_word;

   packet_sender u_sender (
      .r_clk_i          (r_clk_i),
      .r_reset_i        (r_reset_i),
      .r_start_i        (r_start_i),
      .r_dest_i         (r_dest_i),
      .r_len_i          (r_len_i),
      .r_seed_i         (r_seed_i),
      .r_credits_avail_i(r_credits_avail_o),
      .r_wr_o           (r_wr),
      .r_word_o         (r_word),
      .r_busy_o         (r_busy_o)
   );

   cdc_word_buffer u_buffer (
      .r_clk_i     (r_clk_i),
      .r_reset_i   (r_reset_i),
      .r_wr_i      (r_wr),
      .r_word_i    (r_word),
      .w_clk_i     (w_clk_i),
      .w_reset_i   (w_reset_i),
      .w_rd_i      (w_rd),
      .w_word_o    (w_word),
      .w_nonempty_o(w_nonempty)
   );

   packet_consumer u_consumer (
      .w_clk_i      (w_clk_i),
      .w_reset_i    (w_reset_i),
      .w_drain_en_i (w_drain_en_i),
      .w_nonempty_i (w_nonempty),
      .w_word_i     (w_word),
      .w_rd_o       (w_rd),
      .w_inc_token_o(w_inc_token),
      .w_pkt_valid_o(w_pkt_valid_o),
      .w_pkt_dest_o (w_pkt_dest_o),
      .w_pkt_len_o  (w_pkt_len_o),
      .w_pkt_sum_o  (w_pkt_sum_o)
   );

   // each buffer write spends exactly one credit
   async_credit_counter u_credits (
      .r_clk_i          (r_clk_i),
      .r_reset_i        (r_reset_i),
      .r_dec_credit_i   (r_wr),
      .w_clk_i          (w_clk_i),
      .w_reset_i        (w_reset_i),
      .w_inc_token_i    (w_inc_token),
      .r_credits_avail_o(r_credits_avail_o)
   );

endmodule

`default_nettype wire

// File: src/packet_consumer.sv
// ****************************************
// packet consumer
// drains words, totals each packet and returns credit tokens
// ****************************************
`default_nettype none
`include "credit_link_macros.svh"

module packet_consumer (
   input  logic                        w_clk_i,
   input  logic                        w_reset_i,
   input  logic                        w_drain_en_i,
   input  logic                        w_nonempty_i,
   input  credit_link_pkg::link_word_u w_word_i,
   output logic                        w_rd_o,
   output logic                        w_inc_token_o,
   output logic                        w_pkt_valid_o,
   output credit_link_pkg::dest_t      w_pkt_dest_o,
   output credit_link_pkg::len_t       w_pkt_len_o,
   output credit_link_pkg::sum_t       w_pkt_sum_o
);

   import credit_link_pkg::*;

   logic                      in_pay_r;
   dest_t                     cur_dest_r;
   len_t                      cur_len_r;
   len_t                      remain_r;
   sum_t                      acc_r;
   sum_t                      acc_next;
   logic                      last_word;
   logic [`LG_DECIMATION-1:0] credit_cnt_r;
   logic                      token_r;
   logic                      pkt_valid_r;

   // drain is paced from outside, a word is taken whenever one is there
   assign w_rd_o    = w_nonempty_i & w_drain_en_i;
   assign acc_next  = acc_r + sum_t'(w_word_i.data.payload);
   assign last_word = w_rd_o & in_pay_r & (remain_r == len_t'(1));

   // ****************************************
   // packet framing
   // ****************************************

   always_ff @(posedge w_clk_i) begin
      if (w_reset_i) begin
         in_pay_r    <= 1'b0;
         pkt_valid_r <= 1'b0;
      end else begin
         pkt_valid_r <= last_word;
         if (w_rd_o && !in_pay_r && w_word_i.hdr.kind) begin
            in_pay_r <= 1'b1;
         end else if (last_word) begin
            in_pay_r <= 1'b0;
         end
      end
   end

   // header fields open a packet, each data word adds to the running sum
   always_ff @(posedge w_clk_i) begin
      if (w_rd_o && !in_pay_r) begin
         cur_dest_r <= w_word_i.hdr.dest;
         cur_len_r  <= w_word_i.hdr.len;
         remain_r   <= w_word_i.hdr.len;
         acc_r      <= '0;
      end else if (w_rd_o) begin
         remain_r <= remain_r - len_t'(1);
         acc_r    <= acc_next;
      end
   end

   // results hold from one valid pulse to the next
   always_ff @(posedge w_clk_i) begin
      if (last_word) begin
         w_pkt_dest_o <= cur_dest_r;
         w_pkt_len_o  <= cur_len_r;
         w_pkt_sum_o  <= acc_next;
      end
   end

   // ****************************************
   // credit return
   // ****************************************

   // count consumed words, the token goes back once a full group is drained,
   // whatever packet the words belonged to
   always_ff @(posedge w_clk_i) begin
      if (w_reset_i) begin
         credit_cnt_r <= '0;
         token_r      <= 1'b0;
      end else begin
         token_r <= w_rd_o & (&credit_cnt_r);
         if (w_rd_o) begin
            credit_cnt_r <= credit_cnt_r + 1'b1;
         end
      end
   end

   assign w_inc_token_o = token_r;
   assign w_pkt_valid_o = pkt_valid_r;

endmodule

`default_nettype wire

// File: src/packet_sender.sv
// ****************************************
// packet sender
// writes a header and seeded payload words, one credit per word
// ****************************************
`default_nettype none

module packet_sender (
   input  logic                       r_clk_i,
   input  logic                       r_reset_i,
   input  logic                       r_start_i,
   input  credit_link_pkg::dest_t     r_dest_i,
   input  credit_link_pkg::len_t      r_len_i,
   input  logic [14:0]                r_seed_i,
   input  logic                       r_credits_avail_i,
   output logic                       r_wr_o,
   output credit_link_pkg::link_word_u r_word_o,
   output logic                       r_busy_o
);

   import credit_link_pkg::*;

   // FSM encodings
   localparam logic [1:0] st_idle_lp = 2'd0;
   localparam logic [1:0] st_hdr_lp  = 2'd1;
   localparam logic [1:0] st_pay_lp  = 2'd2;

   logic [1:0]  state_r;
   dest_t       dest_r;
   len_t        len_r;
   len_t        remain_r;
   logic [14:0] payload_r;

   // every cycle in a sending state with credits in hand is a write
   assign r_wr_o   = (state_r != st_idle_lp) & r_credits_avail_i;
   assign r_busy_o = (state_r != st_idle_lp);

   always_ff @(posedge r_clk_i) begin
      if (r_reset_i) begin
         state_r <= st_idle_lp;
      end else begin
         case (state_r)
            st_idle_lp: begin
               if (r_start_i) begin
                  state_r <= st_hdr_lp;
               end
            end
            st_hdr_lp: begin
               if (r_credits_avail_i) begin
                  state_r <= st_pay_lp;
               end
            end
            st_pay_lp: begin
               // last payload word leaves, busy drops on the next cycle
               if (r_credits_avail_i && remain_r == len_t'(1)) begin
                  state_r <= st_idle_lp;
               end
            end
            default: state_r <= st_idle_lp;
         endcase
      end
   end

   // request fields are latched on the accepted start, payload steps per write
   always_ff @(posedge r_clk_i) begin
      if (state_r == st_idle_lp && r_start_i) begin
         dest_r    <= r_dest_i;
         len_r     <= r_len_i;
         remain_r  <= r_len_i;
         payload_r <= r_seed_i;
      end else if (state_r == st_pay_lp && r_credits_avail_i) begin
         remain_r  <= remain_r - len_t'(1);
         // wraps modulo 2^15 by width
         payload_r <= payload_r + 15'd1;
      end
   end

   // the word is built through whichever view the state calls for
   always_comb begin
      r_word_o = '0;
      if (state_r == st_hdr_lp) begin
         r_word_o.hdr.kind = 1'b1;
         r_word_o.hdr.dest = dest_r;
         r_word_o.hdr.len  = len_r;
      end else begin
         r_word_o.data.kind    = 1'b0;
         r_word_o.data.payload = payload_r;
      end
   end

endmodule

`default_nettype wire
